/* alu_exec.f */
rtl/alu_pkg.sv
rtl/alu_shifter.sv
rtl/alu_int.sv
rtl/alu_mul.sv
rtl/alu_div.sv
rtl/alu_exec.sv
dv/alu_exec_props.sv
dv/tb_alu_exec.sv

/* Bender.yml */
package:
  name: alu_exec

sources:
  - files:
      - rtl/alu_pkg.sv
      - rtl/alu_shifter.sv
      - rtl/alu_int.sv
      - rtl/alu_mul.sv
      - rtl/alu_div.sv
      - rtl/alu_exec.sv
  - target: simulation
    files:
      - dv/alu_exec_props.sv
      - dv/tb_alu_exec.sv

/* dv/tb_alu_exec.sv */
`timescale 1ns/1ns

module tb_alu_exec;

  localparam int n_int  = 200;
  localparam int n_word = 100;
  localparam int n_md   = 60;
  // word shifts, divide corners, flush sequence, back-to-back pairs
  localparam int n_fixed     = 4 + 8 + 3 + 4;
  localparam int n_reqs      = n_int + n_word + 2 * n_md + n_fixed;
  localparam int cycle_limit = n_reqs * 70 + 100;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  alu_pkg::alu_req_t        req;
  logic [alu_pkg::xlen-1:0] result;
  logic                     busy;

  integer      seed;
  int          cycles;
  int          checks;
  int          errors;
  int          mark_checks;
  int          mark_errors;
  logic [63:0] op_a;
  logic [63:0] op_b;

  alu_pkg::alu_op_e int_ops [11] = '{
    alu_pkg::alu_add, alu_pkg::alu_sub, alu_pkg::alu_sll, alu_pkg::alu_slt,
    alu_pkg::alu_sltu, alu_pkg::alu_xor, alu_pkg::alu_srl, alu_pkg::alu_sra,
    alu_pkg::alu_or, alu_pkg::alu_and, alu_pkg::alu_pass_b
  };
  // the RV64 word forms
  alu_pkg::alu_op_e word_ops [5] = '{
    alu_pkg::alu_add, alu_pkg::alu_sub, alu_pkg::alu_sll, alu_pkg::alu_srl, alu_pkg::alu_sra
  };
  logic [5:0] shamts [4] = '{6'd0, 6'd31, 6'd32, 6'd63};

  alu_exec uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .flush  (flush),
    .result (result),
    .busy   (busy)
  );

  bind alu_exec alu_exec_props u_props (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // mostly random, with zero, minus one and both most-negative values mixed in
  function automatic logic [63:0] pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[2:0])
      3'd0:    return 64'd0;
      3'd1:    return '1;
      3'd2:    return 64'h8000_0000_0000_0000;
      3'd3:    return 64'hffff_ffff_8000_0000;
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic alu_pkg::alu_req_t make_req(alu_pkg::alu_op_e op, alu_pkg::md_op_e md_op,
                                                 logic md_en, logic word,
                                                 logic [63:0] a, logic [63:0] b);
    return '{op: op, md_op: md_op, md_en: md_en, word: word, src1: a, src2: b};
  endfunction

  function automatic logic [63:0] model_int(alu_pkg::alu_op_e op, logic word,
                                            logic [63:0] a, logic [63:0] b);
    logic [5:0]  sh;
    logic [31:0] w;
    logic [63:0] r;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    w  = a[31:0];
    case (op)
      alu_pkg::alu_add:  r = a + b;
      alu_pkg::alu_sub:  r = a - b;
      alu_pkg::alu_sll:  r = a << sh;
      alu_pkg::alu_srl:  r = word ? {32'b0, w >> sh} : a >> sh;
      alu_pkg::alu_sra: begin
        if (word) begin
          w = $signed(w) >>> sh;
          r = {32'b0, w};
        end else begin
          r = $signed(a) >>> sh;
        end
      end
      alu_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_pkg::alu_sltu: r = (a < b) ? 64'd1 : 64'd0;
      alu_pkg::alu_xor:  r = a ^ b;
      alu_pkg::alu_or:   r = a | b;
      alu_pkg::alu_and:  r = a & b;
      default:           r = b;
    endcase
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  function automatic logic [63:0] model_mul(alu_pkg::md_op_e op, logic word,
                                            logic [63:0] a, logic [63:0] b);
    logic signed [128:0] sa;
    logic signed [128:0] sb;
    logic signed [128:0] p;
    sa = (op == alu_pkg::md_mulh || op == alu_pkg::md_mulhsu) ? {{65{a[63]}}, a} : {65'b0, a};
    sb = (op == alu_pkg::md_mulh) ? {{65{b[63]}}, b} : {65'b0, b};
    p  = sa * sb;
    if (op != alu_pkg::md_mul) begin
      return p[127:64];
    end
    return word ? {{32{p[31]}}, p[31:0]} : p[63:0];
  endfunction

  function automatic logic [63:0] model_div(alu_pkg::md_op_e op, logic word,
                                            logic [63:0] a, logic [63:0] b);
    logic               sgn;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        min_v;
    logic [63:0]        q;
    logic [63:0]        r;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sgn   = (op == alu_pkg::md_div) || (op == alu_pkg::md_rem);
    ea    = word ? {{32{sgn & a[31]}}, a[31:0]} : a;
    eb    = word ? {{32{sgn & b[31]}}, b[31:0]} : b;
    min_v = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    sa    = ea;
    sb    = eb;
    if (eb == 64'd0) begin
      q = '1;
      r = ea;
    end else if (sgn && ea == min_v && eb == '1) begin
      q = ea;
      r = 64'd0;
    end else if (sgn) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = ea / eb;
      r = ea % eb;
    end
    r = (op == alu_pkg::md_rem || op == alu_pkg::md_remu) ? r : q;
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  function automatic logic [63:0] expected_result(alu_pkg::alu_req_t r);
    if (!r.md_en) begin
      return model_int(r.op, r.word, r.src1, r.src2);
    end else if (r.md_op >= alu_pkg::md_div) begin
      return model_div(r.md_op, r.word, r.src1, r.src2);
    end
    return model_mul(r.md_op, r.word, r.src1, r.src2);
  endfunction

  // present one request, wait until it is accepted, check result and stall length
  task automatic send_req(input alu_pkg::alu_req_t r);
    logic [63:0] expected;
    int          stall;
    expected = expected_result(r);
    stall    = 0;
    @(negedge clk);
    req   = r;
    flush = 1'b0;
    @(posedge clk);
    while (busy && stall < 70) begin
      stall++;
      @(posedge clk);
    end
    checks += 2;
    if (busy) begin
      $display("request was never accepted, busy still high after %0d cycles", stall);
      errors++;
    end else if (result !== expected) begin
      $display("ERROR %0t ns: result = %h, expected %h (op %s, md_op %s, md_en %b, word %b)",
               $time, result, expected, r.op.name(), r.md_op.name(), r.md_en, r.word);
      errors++;
    end
    if (stall != (r.md_en ? 65 : 0)) begin
      $display("ERROR %0t ns: busy cycles = %0d, expected %0d",
               $time, stall, r.md_en ? 65 : 0);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  // kind 0 integer, 1 word integer, 2 multiply, 3 divide
  task automatic run_random(input int kind, input int n);
    logic [31:0]      sel;
    logic [63:0]      a;
    logic [63:0]      b;
    logic             word;
    alu_pkg::alu_op_e op;
    alu_pkg::md_op_e  mop;
    for (int i = 0; i < n; i++) begin
      sel = $random(seed);
      a   = pick_operand();
      b   = pick_operand();
      op  = (kind == 1) ? word_ops[sel[31:8] % 5] : int_ops[sel[31:8] % 11];
      mop = alu_pkg::md_op_e'({kind == 3, sel[1:0]});
      if (sel[3] && (op == alu_pkg::alu_sll || op == alu_pkg::alu_srl ||
                     op == alu_pkg::alu_sra)) begin
        b[5:0] = shamts[sel[5:4]];
      end
      if (kind < 2) begin
        send_req(make_req(op, alu_pkg::md_mul, 1'b0, kind == 1, a, b));
      end else begin
        // mulh forms have no word variant
        word = sel[2] && (kind == 3 || mop == alu_pkg::md_mul);
        send_req(make_req(alu_pkg::alu_add, mop, 1'b1, word, a, b));
      end
    end
  endtask

  initial begin
    seed        = 32'h2210376a;
    clk         = 1'b0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    req         = '0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    run_random(0, n_int);
    report_test("integer ops");

    // word shifts by 31 and by 32, which the word mask turns into 0
    op_a = 64'h1234_5678_8765_4321;
    send_req(make_req(alu_pkg::alu_sll, alu_pkg::md_mul, 1'b0, 1'b1, op_a, 64'd31));
    send_req(make_req(alu_pkg::alu_srl, alu_pkg::md_mul, 1'b0, 1'b1, op_a, 64'd32));
    send_req(make_req(alu_pkg::alu_sra, alu_pkg::md_mul, 1'b0, 1'b1, op_a, 64'd31));
    send_req(make_req(alu_pkg::alu_sra, alu_pkg::md_mul, 1'b0, 1'b1, op_a, 64'd32));
    run_random(1, n_word);
    report_test("word integer ops");

    run_random(2, n_md);
    report_test("multiply");

    // divide by zero and most negative over minus one, both widths
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_div, 1'b1, 1'b0, op_a, 64'd0));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_remu, 1'b1, 1'b0, op_a, 64'd0));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_divu, 1'b1, 1'b1, op_a, 64'hffff_0000_0000));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_rem, 1'b1, 1'b1, op_a, 64'd0));
    op_b = 64'h8000_0000_0000_0000;
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_div, 1'b1, 1'b0, op_b, '1));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_rem, 1'b1, 1'b0, op_b, '1));
    op_b = 64'hffff_ffff_8000_0000;
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_div, 1'b1, 1'b1, op_b, '1));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_rem, 1'b1, 1'b1, op_b, '1));
    run_random(3, n_md);
    report_test("divide");

    // abort a divide in flight, then an integer op and a fresh divide on the same unit
    op_a = pick_operand();
    op_b = pick_operand();
    @(negedge clk);
    req = make_req(alu_pkg::alu_add, alu_pkg::md_div, 1'b1, 1'b0, op_a, op_b);
    repeat (10) @(negedge clk);
    checks += 2;
    if (!busy) begin
      $display("busy was low while a divide was still running");
      errors++;
    end
    flush = 1'b1;
    @(posedge clk);
    if (busy) begin
      $display("ERROR %0t ns: busy = 1 during flush, expected 0", $time);
      errors++;
    end
    send_req(make_req(alu_pkg::alu_xor, alu_pkg::md_mul, 1'b0, 1'b0, op_a, op_b));
    send_req(make_req(alu_pkg::alu_add, alu_pkg::md_divu, 1'b1, 1'b0, op_a, op_b));
    report_test("flush");

    // identical requests in a row, each one has to start and stall on its own
    repeat (2) send_req(make_req(alu_pkg::alu_add, alu_pkg::md_mulh, 1'b1, 1'b0, op_a, op_b));
    repeat (2) send_req(make_req(alu_pkg::alu_add, alu_pkg::md_rem, 1'b1, 1'b1, op_a, op_b));
    report_test("back-to-back");

    $display("checks passed: %0d, check errors: %0d, assertion failures: %0d",
             checks - errors, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* dv/alu_exec_props.sv */
`timescale 1ns/1ns

module alu_exec_props (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic busy,
  input logic mul_start,
  input logic div_start,
  input logic mul_done,
  input logic div_done
);

  int fail_count = 0;

  // 64 iteration cycles plus the done cycle
  busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> ##[1:66] !busy)
    else begin
      fail_count++;
      $error("busy stayed high for more than 66 cycles");
    end

  no_start_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> !(mul_start || div_start))
    else begin
      fail_count++;
      $error("start pulse while flush is high");
    end

  busy_low_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !busy)
    else begin
      fail_count++;
      $error("busy high in the cycle after flush");
    end

  // done is a pulse, one unit at a time
  single_cycle_done: assert property (@(posedge clk) disable iff (!rst_n)
    (mul_done || div_done) |=> !(mul_done || div_done))
    else begin
      fail_count++;
      $error("done high for two cycles in a row");
    end

endmodule

/* rtl/alu_exec.sv */
`timescale 1ns/1ns

module alu_exec (
  input  logic                     clk,
  input  logic                     rst_n,
  input  alu_pkg::alu_req_t        req,
  input  logic                     flush,
  output logic [alu_pkg::xlen-1:0] result,
  output logic                     busy
);

  logic [alu_pkg::xlen-1:0] int_result;
  logic [alu_pkg::xlen-1:0] mul_result;
  logic [alu_pkg::xlen-1:0] div_result;
  logic                     is_div;
  logic                     issued;
  logic                     md_start;
  logic                     md_done;
  logic                     mul_start;
  logic                     div_start;
  logic                     mul_done;
  logic                     div_done;

  // md_op bit 2 picks the divider
  assign is_div = req.md_op[2];

  // one start per request, only before it has been issued
  assign md_start  = req.md_en && !issued && !flush;
  assign mul_start = md_start && !is_div;
  assign div_start = md_start && is_div;
  assign md_done   = is_div ? div_done : mul_done;

  // stall until the chosen unit reports done
  assign busy = req.md_en && !md_done && !flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issued <= 1'b0;
    end else if (flush) begin
      issued <= 1'b0;
    end else if (md_start) begin
      issued <= 1'b1;
    end else if (md_done) begin
      issued <= 1'b0;
    end
  end

  alu_int u_int (
    .op         (req.op),
    .word       (req.word),
    .src1       (req.src1),
    .src2       (req.src2),
    .int_result (int_result)
  );

  alu_mul u_mul (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (mul_start),
    .flush      (flush),
    .md_op      (req.md_op),
    .word       (req.word),
    .src1       (req.src1),
    .src2       (req.src2),
    .done       (mul_done),
    .mul_result (mul_result)
  );

  alu_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (div_start),
    .flush      (flush),
    .md_op      (req.md_op),
    .word       (req.word),
    .src1       (req.src1),
    .src2       (req.src2),
    .done       (div_done),
    .div_result (div_result)
  );

  always_comb begin
    if (!req.md_en) begin
      result = int_result;
    end else if (is_div) begin
      result = div_result;
    end else begin
      result = mul_result;
    end
  end

endmodule

/* rtl/alu_div.sv */
`timescale 1ns/1ns

module alu_div (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     flush,
  input  alu_pkg::md_op_e          md_op,
  input  logic                     word,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic                     done,
  output logic [alu_pkg::xlen-1:0] div_result
);

  alu_pkg::md_state_e          state;
  logic [alu_pkg::cnt_w-1:0]   cnt;
  logic                        last_step;

  logic [alu_pkg::xlen-1:0]    quo;
  logic [alu_pkg::xlen-1:0]    rem;
  logic [alu_pkg::xlen-1:0]    dvsr;
  logic [alu_pkg::xlen-1:0]    dvd_q;
  logic                        q_neg_q;
  logic                        r_neg_q;
  logic                        zero_q;
  logic                        ovf_q;
  logic                        sel_rem_q;
  logic                        word_q;

  logic                        is_signed;
  logic [alu_pkg::xlen-1:0]    ext_a;
  logic [alu_pkg::xlen-1:0]    ext_b;
  logic [alu_pkg::xlen-1:0]    most_neg;
  logic                        a_neg;
  logic                        b_neg;
  logic [alu_pkg::xlen:0]      rem_sh;
  logic [alu_pkg::xlen:0]      diff;
  logic                        fits;
  logic [alu_pkg::xlen-1:0]    rem_next;
  logic [alu_pkg::xlen-1:0]    quo_next;
  logic [alu_pkg::xlen-1:0]    q_out;
  logic [alu_pkg::xlen-1:0]    r_out;
  logic [alu_pkg::xlen-1:0]    pick;

  assign is_signed = (md_op == alu_pkg::md_div) || (md_op == alu_pkg::md_rem);

  // word operands widened from bit 31
  assign ext_a = !word ? src1 :
                 is_signed ? {{32{src1[31]}}, src1[31:0]} : {32'b0, src1[31:0]};
  assign ext_b = !word ? src2 :
                 is_signed ? {{32{src2[31]}}, src2[31:0]} : {32'b0, src2[31:0]};

  assign most_neg = word ? {{33{1'b1}}, 31'b0} : {1'b1, {(alu_pkg::xlen-1){1'b0}}};
  assign a_neg    = is_signed & ext_a[alu_pkg::xlen-1];
  assign b_neg    = is_signed & ext_b[alu_pkg::xlen-1];

  // restoring step, next dividend bit shifted into the partial remainder
  assign rem_sh   = {rem, quo[alu_pkg::xlen-1]};
  assign diff     = rem_sh - {1'b0, dvsr};
  assign fits     = ~diff[alu_pkg::xlen];
  assign rem_next = fits ? diff[alu_pkg::xlen-1:0] : rem_sh[alu_pkg::xlen-1:0];
  assign quo_next = {quo[alu_pkg::xlen-2:0], fits};

  always_comb begin
    if (zero_q) begin
      q_out = {alu_pkg::xlen{1'b1}};
      r_out = dvd_q;
    end else if (ovf_q) begin
      q_out = dvd_q;
      r_out = '0;
    end else begin
      q_out = q_neg_q ? -quo_next : quo_next;
      // remainder takes the dividend's sign
      r_out = r_neg_q ? -rem_next : rem_next;
    end
  end

  assign pick = sel_rem_q ? r_out : q_out;

  assign last_step = (state == alu_pkg::md_run) && (cnt == {alu_pkg::cnt_w{1'b1}});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= alu_pkg::md_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else if (flush) begin
      state <= alu_pkg::md_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= last_step;
      case (state)
        alu_pkg::md_idle: begin
          if (start) begin
            state <= alu_pkg::md_run;
            cnt   <= '0;
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= alu_pkg::md_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && !flush && state == alu_pkg::md_idle) begin
      quo       <= a_neg ? -ext_a : ext_a;
      rem       <= '0;
      dvsr      <= b_neg ? -ext_b : ext_b;
      dvd_q     <= ext_a;
      q_neg_q   <= a_neg ^ b_neg;
      r_neg_q   <= a_neg;
      zero_q    <= (ext_b == '0);
      ovf_q     <= is_signed && (ext_a == most_neg) && (ext_b == {alu_pkg::xlen{1'b1}});
      sel_rem_q <= (md_op == alu_pkg::md_rem) || (md_op == alu_pkg::md_remu);
      word_q    <= word;
    end else if (state == alu_pkg::md_run) begin
      quo <= quo_next;
      rem <= rem_next;
      if (last_step && !flush) begin
        div_result <= word_q ? {{32{pick[31]}}, pick[31:0]} : pick;
      end
    end
  end

endmodule

/* rtl/alu_mul.sv */
`timescale 1ns/1ns

module alu_mul (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     flush,
  input  alu_pkg::md_op_e          md_op,
  input  logic                     word,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic                     done,
  output logic [alu_pkg::xlen-1:0] mul_result
);

  alu_pkg::md_state_e          state;
  logic [alu_pkg::cnt_w-1:0]   cnt;
  logic                        last_step;

  // {high, low} product, low half starts as the multiplier
  logic [2*alu_pkg::xlen-1:0]  prod;
  logic [alu_pkg::xlen-1:0]    mcand;
  logic                        neg_q;
  logic                        sel_hi_q;
  logic                        word_q;

  logic                        a_signed;
  logic                        b_signed;
  logic                        a_neg;
  logic                        b_neg;
  logic [alu_pkg::xlen-1:0]    a_mag;
  logic [alu_pkg::xlen-1:0]    b_mag;
  logic [alu_pkg::xlen:0]      part_sum;
  logic [2*alu_pkg::xlen-1:0]  prod_next;
  logic [2*alu_pkg::xlen-1:0]  prod_fix;
  logic [alu_pkg::xlen-1:0]    res_next;

  // mul and mulhu treated as unsigned, low half is the same either way
  assign a_signed = (md_op == alu_pkg::md_mulh) || (md_op == alu_pkg::md_mulhsu);
  assign b_signed = (md_op == alu_pkg::md_mulh);
  assign a_neg    = a_signed & src1[alu_pkg::xlen-1];
  assign b_neg    = b_signed & src2[alu_pkg::xlen-1];
  assign a_mag    = a_neg ? -src1 : src1;
  assign b_mag    = b_neg ? -src2 : src2;

  // one shift-add step
  assign part_sum  = {1'b0, prod[2*alu_pkg::xlen-1:alu_pkg::xlen]} +
                     ({1'b0, mcand} & {(alu_pkg::xlen+1){prod[0]}});
  assign prod_next = {part_sum, prod[alu_pkg::xlen-1:1]};
  assign prod_fix  = neg_q ? -prod_next : prod_next;

  always_comb begin
    if (sel_hi_q) begin
      res_next = prod_fix[2*alu_pkg::xlen-1:alu_pkg::xlen];
    end else if (word_q) begin
      res_next = {{32{prod_fix[31]}}, prod_fix[31:0]};
    end else begin
      res_next = prod_fix[alu_pkg::xlen-1:0];
    end
  end

  assign last_step = (state == alu_pkg::md_run) && (cnt == {alu_pkg::cnt_w{1'b1}});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= alu_pkg::md_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else if (flush) begin
      state <= alu_pkg::md_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= last_step;
      case (state)
        alu_pkg::md_idle: begin
          if (start) begin
            state <= alu_pkg::md_run;
            cnt   <= '0;
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= alu_pkg::md_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && !flush && state == alu_pkg::md_idle) begin
      prod     <= {{alu_pkg::xlen{1'b0}}, b_mag};
      mcand    <= a_mag;
      neg_q    <= a_neg ^ b_neg;
      sel_hi_q <= (md_op != alu_pkg::md_mul);
      word_q   <= word;
    end else if (state == alu_pkg::md_run) begin
      prod <= prod_next;
      // result register holds until the next start
      if (last_step && !flush) begin
        mul_result <= res_next;
      end
    end
  end

endmodule

/* rtl/alu_int.sv */
`timescale 1ns/1ns

module alu_int (
  input  alu_pkg::alu_op_e         op,
  input  logic                     word,
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [alu_pkg::xlen-1:0] src2,
  output logic [alu_pkg::xlen-1:0] int_result
);

  logic                     sub_en;
  logic [alu_pkg::xlen-1:0] b_in;
  logic [alu_pkg::xlen-1:0] sum;
  logic                     carry;
  logic                     overflow;
  logic                     less_s;
  logic                     less_u;
  logic [alu_pkg::xlen-1:0] shift_result;
  logic [alu_pkg::xlen-1:0] sel;

  // compares share the subtractor
  assign sub_en = (op == alu_pkg::alu_sub) ||
                  (op == alu_pkg::alu_slt) ||
                  (op == alu_pkg::alu_sltu);

  // a - b as a + ~b + 1
  assign b_in = src2 ^ {alu_pkg::xlen{sub_en}};
  assign {carry, sum} = {1'b0, src1} + {1'b0, b_in} + {{alu_pkg::xlen{1'b0}}, sub_en};

  assign overflow = (src1[alu_pkg::xlen-1] == b_in[alu_pkg::xlen-1]) &&
                    (sum[alu_pkg::xlen-1] != src1[alu_pkg::xlen-1]);

  assign less_s = sum[alu_pkg::xlen-1] ^ overflow;
  // no carry out of a + ~b + 1 means a borrow
  assign less_u = ~carry;

  alu_shifter u_shifter (
    .src1         (src1),
    .shamt        (src2[5:0]),
    .word         (word),
    .op           (op),
    .shift_result (shift_result)
  );

  always_comb begin
    case (op)
      alu_pkg::alu_add,
      alu_pkg::alu_sub:    sel = sum;
      alu_pkg::alu_sll,
      alu_pkg::alu_srl,
      alu_pkg::alu_sra:    sel = shift_result;
      alu_pkg::alu_slt:    sel = {{(alu_pkg::xlen-1){1'b0}}, less_s};
      alu_pkg::alu_sltu:   sel = {{(alu_pkg::xlen-1){1'b0}}, less_u};
      alu_pkg::alu_xor:    sel = src1 ^ src2;
      alu_pkg::alu_or:     sel = src1 | src2;
      alu_pkg::alu_and:    sel = src1 & src2;
      alu_pkg::alu_pass_b: sel = src2;
      default:             sel = sum;
    endcase
  end

  // word forms return bit 31 sign-extended
  assign int_result = word ? {{32{sel[31]}}, sel[31:0]} : sel;

endmodule

/* rtl/alu_shifter.sv */
`timescale 1ns/1ns

module alu_shifter (
  input  logic [alu_pkg::xlen-1:0] src1,
  input  logic [5:0]               shamt,
  input  logic                     word,
  input  alu_pkg::alu_op_e         op,
  output logic [alu_pkg::xlen-1:0] shift_result
);

  logic [5:0]               amt;
  logic [alu_pkg::xlen-1:0] right_src;
  logic [alu_pkg::xlen-1:0] shift_src;
  logic [alu_pkg::xlen-1:0] shifted;
  logic [alu_pkg::xlen-1:0] fill_mask;
  logic [alu_pkg::xlen-1:0] sra_fill;
  logic                     is_left;
  logic                     sign_bit;

  function automatic logic [alu_pkg::xlen-1:0] bit_rev(input logic [alu_pkg::xlen-1:0] v);
    logic [alu_pkg::xlen-1:0] r;
    for (int i = 0; i < alu_pkg::xlen; i++) begin
      r[i] = v[alu_pkg::xlen-1-i];
    end
    return r;
  endfunction

  assign is_left = (op == alu_pkg::alu_sll);

  // word shifts only look at 5 bits of shamt
  assign amt = word ? {1'b0, shamt[4:0]} : shamt;

  // left shift is a right shift of the mirrored operand
  assign right_src = word ? {32'b0, src1[31:0]} : src1;
  assign shift_src = is_left ? bit_rev(src1) : right_src;
  assign shifted   = shift_src >> amt;

  // ones in the top amt bits, moved down to bit 31 in word mode
  assign fill_mask = ~({alu_pkg::xlen{1'b1}} >> amt);
  assign sign_bit  = word ? src1[31] : src1[63];
  assign sra_fill  = (word ? {32'b0, fill_mask[63:32]} : fill_mask) &
                     {alu_pkg::xlen{sign_bit}};

  always_comb begin
    case (op)
      alu_pkg::alu_sll: shift_result = bit_rev(shifted);
      alu_pkg::alu_sra: shift_result = shifted | sra_fill;
      // srl, zeros already shifted in from the zero-extended source
      default:          shift_result = shifted;
    endcase
  end

endmodule

/* rtl/alu_pkg.sv */
package alu_pkg;

  // datapath width, fixed by RV64
  localparam int xlen = 64;

  // iteration counter width for the multiply and divide units
  localparam int cnt_w = $clog2(xlen);

  // integer operations
  // bit 3 selects sub, unsigned compare or arithmetic shift
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_pass_b = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_sltu   = 4'b1010,
    alu_sra    = 4'b1101
  } alu_op_e;

  // M extension, same order as funct3
  // bit 2 set means the divider
  typedef enum logic [2:0] {
    md_mul    = 3'd0,
    md_mulh   = 3'd1,
    md_mulhsu = 3'd2,
    md_mulhu  = 3'd3,
    md_div    = 3'd4,
    md_divu   = 3'd5,
    md_rem    = 3'd6,
    md_remu   = 3'd7
  } md_op_e;

  // iterative unit states
  typedef enum logic {
    md_idle = 1'b0,
    md_run  = 1'b1
  } md_state_e;

  // issued instruction, 137 bits
  typedef struct packed {
    alu_op_e          op;
    md_op_e           md_op;
    // route to multiply/divide instead of the integer path
    logic             md_en;
    // 32-bit word form
    logic             word;
    logic [xlen-1:0]  src1;
    logic [xlen-1:0]  src2;
  } alu_req_t;

endpackage
